/* Makefile */
# Verilator flow for the execute slice, the sim target fails unless sim.log holds the pass line
TOP := exec_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q -F '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

/* logic/alu_unit.sv */
// One-cycle ALU for RV32I arithmetic; reserved opcodes yield zero and no back-pressure exists
`timescale 1ns/1ns
`default_nettype none

module alu_unit (
  input  logic              clk,
  input  logic              reset_n,
  input  exec_pkg::id_ex_t  stage,
  output exec_pkg::ex_wb_t  wb
);

  logic [exec_pkg::xlen-1:0]        op1;
  logic [exec_pkg::xlen-1:0]        op2;
  logic signed [exec_pkg::xlen-1:0] op1_s;
  logic signed [exec_pkg::xlen-1:0] op2_s;
  logic [exec_pkg::shamt_w-1:0]     shamt;
  logic                             lt_s;
  logic                             lt_u;
  logic [exec_pkg::xlen-1:0]        result;
  exec_pkg::ex_wb_t                 wb_d;
  exec_pkg::ex_wb_t                 wb_q;

  assign op1 = stage.op1;
  assign op2 = stage.op2;

  // Signed views for compare and arithmetic shift
  assign op1_s = stage.op1;
  assign op2_s = stage.op2;

  // Only the low bits of op2 count as shift amount
  assign shamt = stage.op2[exec_pkg::shamt_w-1:0];

  // Set-less-than flags
  assign lt_s = (op1_s < op2_s);
  assign lt_u = (op1 < op2);

  always_comb begin
    case (stage.alu_op)
      exec_pkg::ADD: begin
        result = op1 + op2;
      end
      exec_pkg::SUB: begin
        result = op1 - op2;
      end
      exec_pkg::SLL: begin
        result = op1 << shamt;
      end
      exec_pkg::SRL: begin
        result = op1 >> shamt;
      end
      exec_pkg::SRA: begin
        // Arithmetic shift fills with the sign bit
        result = op1_s >>> shamt;
      end
      exec_pkg::SLT: begin
        result = {{(exec_pkg::xlen-1){1'b0}}, lt_s};
      end
      exec_pkg::SLTU: begin
        result = {{(exec_pkg::xlen-1){1'b0}}, lt_u};
      end
      exec_pkg::XOR: begin
        result = op1 ^ op2;
      end
      exec_pkg::OR: begin
        result = op1 | op2;
      end
      exec_pkg::AND: begin
        result = op1 & op2;
      end
      // Multiply and divide are not implemented
      default: begin
        result = '0;
      end
    endcase
  end

  // Next write-back record
  always_comb begin
    wb_d.valid  = stage.valid;
    wb_d.rd     = stage.rd;
    wb_d.result = result;
  end

  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      wb_q <= exec_pkg::ex_wb_empty;
    end else begin
      wb_q <= wb_d;
    end
  end

  assign wb = wb_q;

endmodule : alu_unit

`default_nettype wire

/* logic/exec_pkg.sv */
// Integer RV32 execute slice only; multiply/divide codes are reserved and never issued
`default_nettype none

package exec_pkg;

  // Data path and register index widths
  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // Immediate, shift amount and opcode widths
  localparam int imm_w = 12;
  localparam int shamt_w = $clog2(xlen);
  localparam int alu_op_w = 5;

  // ALU operations; the low eight follow funct3 order
  typedef enum logic [alu_op_w-1:0] {
    ADD,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    OR,
    AND,
    SUB = 5'b01000,
    SRA = 5'b01101,
    // M extension, kept for encoding space only
    MUL,
    MULH,
    MULHSU,
    MULHU,
    DIV,
    DIVU,
    REM,
    REMU
  } alu_op_t;

  // One issued R-type or I-type arithmetic instruction
  typedef struct packed {
    logic [2:0]            fun3;
    logic [6:0]            fun7;
    logic [reg_addr_w-1:0] rd;
    logic [imm_w-1:0]      imm12;
    logic                  alu_src;   // 1 selects the immediate
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic [xlen-1:0]       pc;        // trace only
    logic                  spare;
  } issue_t;

  // Decoded ALU request held in the ID/EX register
  typedef struct packed {
    logic                  valid;
    alu_op_t               alu_op;
    logic [xlen-1:0]       op1;
    logic [xlen-1:0]       op2;
    logic [reg_addr_w-1:0] rd;
  } id_ex_t;

  // Write-back record, valid doubles as the result strobe
  typedef struct packed {
    logic                  valid;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       result;
  } ex_wb_t;

  // Empty request, loaded on reset and on flush
  localparam id_ex_t id_ex_empty = '0;

  // Cleared write-back record after reset
  localparam ex_wb_t ex_wb_empty = '0;

endpackage

`default_nettype wire

/* logic/exec_top.sv */
// Execute slice with fixed two-cycle issue-to-result latency; flush drops only the same-cycle issue
`timescale 1ns/1ns
`default_nettype none

module exec_top (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              issue_valid,
  input  exec_pkg::issue_t  issue,
  input  logic              flush,
  output exec_pkg::ex_wb_t  wb
);

  exec_pkg::id_ex_t decoded;
  exec_pkg::id_ex_t stage;

  // Producer, combinational decode
  inst_decode u_inst_decode (
    .issue_valid (issue_valid),
    .issue       (issue),
    .decoded     (decoded)
  );

  // ID/EX pipeline register
  id_ex_reg u_id_ex_reg (
    .clk     (clk),
    .reset_n (reset_n),
    .flush   (flush),
    .decoded (decoded),
    .stage   (stage)
  );

  // Consumer, ALU with registered write-back
  alu_unit u_alu_unit (
    .clk     (clk),
    .reset_n (reset_n),
    .stage   (stage),
    .wb      (wb)
  );

endmodule : exec_top

`default_nettype wire

/* logic/id_ex_reg.sv */
// Loads every cycle with no enable; flush wins over the load and drops the incoming request
`timescale 1ns/1ns
`default_nettype none

module id_ex_reg (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              flush,
  input  exec_pkg::id_ex_t  decoded,
  output exec_pkg::id_ex_t  stage
);

  exec_pkg::id_ex_t stage_q;
  exec_pkg::id_ex_t stage_d;

  // Clear takes priority over the incoming request
  always_comb begin
    if (flush) begin
      stage_d = exec_pkg::id_ex_empty;
    end else begin
      stage_d = decoded;
    end
  end

  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      stage_q <= exec_pkg::id_ex_empty;
    end else begin
      stage_q <= stage_d;
    end
  end

  assign stage = stage_q;

endmodule : id_ex_reg

`default_nettype wire

/* logic/inst_decode.sv */
// Combinational; decodes only OP and OP-IMM arithmetic, funct7 bit 5 is the sole funct7 bit used
`timescale 1ns/1ns
`default_nettype none

module inst_decode (
  input  logic              issue_valid,
  input  exec_pkg::issue_t  issue,
  output exec_pkg::id_ex_t  decoded
);

  exec_pkg::alu_op_t         alu_op;
  logic [exec_pkg::xlen-1:0] imm_ext;
  logic [exec_pkg::xlen-1:0] op2;
  logic                      alt_op;

  // funct7 bit 5 picks the alternate form of add and right shift
  assign alt_op = issue.fun7[5];

  // Sign extension of the I-type immediate
  assign imm_ext = {
    {(exec_pkg::xlen - exec_pkg::imm_w){issue.imm12[exec_pkg::imm_w-1]}},
    issue.imm12
  };

  // Operation select from funct3
  always_comb begin
    case (issue.fun3)
      3'b000: begin
        // No SUBI, an immediate source always adds
        if (alt_op && !issue.alu_src) begin
          alu_op = exec_pkg::SUB;
        end else begin
          alu_op = exec_pkg::ADD;
        end
      end
      3'b001: alu_op = exec_pkg::SLL;
      3'b010: alu_op = exec_pkg::SLT;
      3'b011: alu_op = exec_pkg::SLTU;
      3'b100: alu_op = exec_pkg::XOR;
      3'b101: begin
        // SRA and SRAI share the same funct7 marker
        if (alt_op) begin
          alu_op = exec_pkg::SRA;
        end else begin
          alu_op = exec_pkg::SRL;
        end
      end
      3'b110: alu_op = exec_pkg::OR;
      default: alu_op = exec_pkg::AND;
    endcase
  end

  // Second operand source
  always_comb begin
    if (issue.alu_src) begin
      op2 = imm_ext;
    end else begin
      op2 = issue.rs2_data;
    end
  end

  // Request toward the ID/EX register
  always_comb begin
    decoded.valid  = issue_valid;
    decoded.alu_op = alu_op;
    decoded.op1    = issue.rs1_data;
    decoded.op2    = op2;
    decoded.rd     = issue.rd;
  end

endmodule : inst_decode

`default_nettype wire

/* project.f */
logic/exec_pkg.sv
logic/inst_decode.sv
logic/id_ex_reg.sv
logic/alu_unit.sv
logic/exec_top.sv
test/exec_sva.sv
test/exec_checker.sv
test/exec_tb.sv

/* test/exec_checker.sv */
// Samples on the falling edge, where inputs and wb are stable; queue is emptied during reset
`timescale 1ns/1ns
`default_nettype none

module exec_checker (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             issue_valid,
  input  exec_pkg::issue_t issue,
  input  logic             flush,
  input  exec_pkg::ex_wb_t wb,
  input  logic             end_of_test,
  output int               errors
);

  typedef struct packed {
    logic [exec_pkg::reg_addr_w-1:0] rd;
    logic [exec_pkg::xlen-1:0]       result;
  } expect_t;

  expect_t expect_q[$];
  expect_t item;
  expect_t head;
  int      err_count = 0;
  logic    end_seen = 1'b0;

  assign errors = err_count;

  // Expected result from the RV32I arithmetic rules
  function automatic logic [31:0] ref_result(input exec_pkg::issue_t ins);
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    logic        alt;
    a = ins.rs1_data;
    b = ins.alu_src ? {{20{ins.imm12[11]}}, ins.imm12} : ins.rs2_data;
    sh = b[4:0];
    alt = ins.fun7[5];
    case (ins.fun3)
      3'd0: ref_result = (alt && !ins.alu_src) ? a - b : a + b;
      3'd1: ref_result = a << sh;
      // Differing signs decide signed order by the sign of a
      3'd2: ref_result = {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
      3'd3: ref_result = {31'd0, a < b};
      3'd4: ref_result = a ^ b;
      3'd5: ref_result = (alt && a[31]) ? (a >> sh) | ~(32'hffff_ffff >> sh) : a >> sh;
      3'd6: ref_result = a | b;
      default: ref_result = a & b;
    endcase
  endfunction

  always @(negedge clk) begin
    if (!reset_n) begin
      expect_q.delete();
    end else begin
      if (wb.valid) begin
        if (expect_q.size() == 0) begin
          $display("error at %0t: wb.valid with no instruction outstanding", $time);
          err_count++;
        end else begin
          head = expect_q.pop_front();
          if (wb.rd !== head.rd) begin
            $display("mismatch at %0t: wb.rd expected %0d got %0d", $time, head.rd, wb.rd);
            err_count++;
          end
          if (wb.result !== head.result) begin
            $display("mismatch at %0t: wb.result expected %h got %h",
                     $time, head.result, wb.result);
            err_count++;
          end
        end
      end
      if (issue_valid && !flush) begin
        item.rd = issue.rd;
        item.result = ref_result(issue);
        expect_q.push_back(item);
      end
    end
    if (end_of_test && !end_seen) begin
      end_seen = 1'b1;
      if (expect_q.size() != 0) begin
        $display("error: %0d issued instructions never reached wb", expect_q.size());
        err_count++;
      end
    end
  end

endmodule : exec_checker

`default_nettype wire

/* test/exec_sva.sv */
// Bound into exec_top; properties are off while reset_n is low except the reset check
`timescale 1ns/1ns
`default_nettype none

module exec_sva (
  input logic             clk,
  input logic             reset_n,
  input logic             issue_valid,
  input logic             flush,
  input exec_pkg::ex_wb_t wb
);

  int sva_errors = 0;

  // No result strobe while reset is held
  reset_quiet: assert property (@(posedge clk) !reset_n |-> !wb.valid)
    else begin
      sva_errors++;
      $error("wb.valid high while reset is asserted");
    end

  // Unflushed issue lands two cycles later
  issue_latency: assert property (@(posedge clk) disable iff (!reset_n)
    (issue_valid && !flush) |-> ##2 wb.valid)
    else begin
      sva_errors++;
      $error("wb.valid missing two cycles after an issue");
    end

  // Flushed issue never produces a result
  flush_drop: assert property (@(posedge clk) disable iff (!reset_n)
    (issue_valid && flush) |-> ##2 !wb.valid)
    else begin
      sva_errors++;
      $error("wb.valid seen for a flushed issue");
    end

endmodule : exec_sva

`default_nettype wire

/* test/exec_tb.sv */
// Needs Verilator --timing; fixed seed, so every run replays the same stimulus
`timescale 1ns/1ns
`default_nettype none

module exec_tb;

  // Reset, directed, immediate, random, flush, mid-run reset, drain
  localparam int stim_cycles = 8 + 60 + 64 + 300 + 65 + 48 + 6;
  localparam int cycle_limit = stim_cycles + 50;

  localparam logic [31:0] dir_a [0:5] = '{32'h0, 32'h7fffffff, 32'h80000000,
                                          32'hffffffff, 32'h80000000, 32'h7fffffff};
  localparam logic [31:0] dir_b [0:5] = '{32'h0, 32'h1, 32'hffffffff,
                                          32'hffffffff, 32'h1f, 32'h80000000};
  localparam logic [11:0] dir_imm [0:3] = '{12'h800, 12'hfff, 12'h7ff, 12'h41f};

  logic             clk;
  logic             reset_n;
  logic             issue_valid;
  logic             flush;
  logic             end_of_test;
  exec_pkg::issue_t issue;
  exec_pkg::ex_wb_t wb;
  exec_pkg::issue_t ins;
  int               seed = 32'h2d71;
  int               cycle_count = 0;
  int               chk_errors;

  exec_top DUT (
    .clk         (clk),
    .reset_n     (reset_n),
    .issue_valid (issue_valid),
    .issue       (issue),
    .flush       (flush),
    .wb          (wb)
  );

  exec_checker u_checker (
    .clk         (clk),
    .reset_n     (reset_n),
    .issue_valid (issue_valid),
    .issue       (issue),
    .flush       (flush),
    .wb          (wb),
    .end_of_test (end_of_test),
    .errors      (chk_errors)
  );

  bind exec_top exec_sva u_exec_sva (
    .clk         (clk),
    .reset_n     (reset_n),
    .issue_valid (issue_valid),
    .flush       (flush),
    .wb          (wb)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  task automatic drive_cycle(input logic valid, input exec_pkg::issue_t i, input logic fl);
    @(posedge clk);
    #5;
    issue_valid = valid;
    issue = i;
    flush = fl;
  endtask

  // Back-to-back random issues, flush on about one cycle in eight if asked
  task automatic random_run(input int n, input logic with_flush);
    logic [31:0] r;
    repeat (n) begin
      r = $random(seed);
      ins.fun3 = r[2:0];
      ins.fun7 = r[9:3];
      ins.rd = r[14:10];
      ins.imm12 = r[26:15];
      ins.alu_src = r[27];
      ins.spare = r[28];
      ins.rs1_data = $random(seed);
      ins.rs2_data = $random(seed);
      ins.pc = $random(seed);
      drive_cycle(1'b1, ins, with_flush && (r[31:29] == 3'd0));
    end
  endtask

  initial begin
    reset_n = 1'b0;
    issue_valid = 1'b0;
    flush = 1'b0;
    issue = '0;
    end_of_test = 1'b0;
    repeat (8) @(posedge clk);
    #5;
    reset_n = 1'b1;
    // Register sources, SUB and SRA last in each group
    for (int p = 0; p < 6; p++) begin
      for (int op = 0; op < 10; op++) begin
        ins = '0;
        ins.fun3 = (op == 9) ? 3'd5 : op[2:0];
        ins.fun7 = (op >= 8) ? 7'h20 : 7'h00;
        ins.rd = 5'(p * 10 + op);
        ins.rs1_data = dir_a[p];
        ins.rs2_data = dir_b[p];
        drive_cycle(1'b1, ins, 1'b0);
      end
    end
    // Immediate forms, second pass with funct7 bit 5 set
    for (int h = 0; h < 2; h++) begin
      for (int f = 0; f < 8; f++) begin
        for (int k = 0; k < 4; k++) begin
          ins = '0;
          ins.fun3 = f[2:0];
          ins.fun7 = (h == 1) ? 7'h20 : 7'h00;
          ins.alu_src = 1'b1;
          ins.imm12 = dir_imm[k];
          ins.rs1_data = k[0] ? 32'h8000_0010 : 32'h7fff_fff0;
          ins.rs2_data = 32'h5a5a_5a5a;
          ins.rd = 5'(f * 4 + k);
          drive_cycle(1'b1, ins, 1'b0);
        end
      end
    end
    random_run(300, 1'b0);
    drive_cycle(1'b0, '0, 1'b1);
    repeat (4) drive_cycle(1'b0, '0, 1'b0);
    random_run(60, 1'b1);
    // Reset lands while results are still in flight
    random_run(20, 1'b0);
    reset_n = 1'b0;
    random_run(8, 1'b0);
    reset_n = 1'b1;
    random_run(20, 1'b0);
    repeat (6) drive_cycle(1'b0, '0, 1'b0);
    end_of_test = 1'b1;
    @(posedge clk);
    $display("exec_tb done: %0d checker errors, %0d assertion errors",
             chk_errors, DUT.u_exec_sva.sva_errors);
    if (chk_errors + DUT.u_exec_sva.sva_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: test did not finish within %0d cycles", cycle_limit);
    $display("exec_tb stopped: %0d checker errors, %0d assertion errors",
             chk_errors, DUT.u_exec_sva.sva_errors);
    $display("** FAIL **");
    $finish;
  end

endmodule : exec_tb

`default_nettype wire
